// File: bench/cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic req,
    input wire logic ready,
    input wire logic resp_valid,
    input wire logic refill_req,
    input wire logic refill_valid
);

    logic miss_pend;
    int   fail_answer = 0;
    int   fail_refill = 0;
    int   fail_resp = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_pend <= 1'b0;
        end else if (refill_req) begin
            miss_pend <= 1'b1;
        end else if (refill_valid) begin
            miss_pend <= 1'b0;
        end
    end

    // Exactly one strobe answers each accepted request.
    a_req_answer: assert property (@(posedge clk) disable iff (!rst_n)
        (req && ready) |=> (resp_valid != refill_req))
        else begin
            $error("accepted request not answered by exactly one strobe one cycle later");
            fail_answer++;
        end

    a_refill_src: assert property (@(posedge clk) disable iff (!rst_n)
        refill_req |-> $past(req && ready))
        else begin
            $error("refill_req without an accepted request");
            fail_refill++;
        end

    a_resp_src: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> ($past(req && ready) || $past(refill_valid && miss_pend)))
        else begin
            $error("resp_valid without a request or a refill");
            fail_resp++;
        end

endmodule

`default_nettype wire

// File: bench/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int NUM_REQ    = 320;
    localparam int MAX_CYCLES = NUM_REQ * 20 + 100;  // Margin covers reset.
    localparam int WORDS      = `CACHE_LINE_W / 32;

    logic        clk;
    logic        rst_n;
    logic        req;
    cache_addr_t req_addr;
    logic        ready;
    logic        resp_valid;
    logic [31:0] resp_data;
    logic        refill_req;
    logic [31:0] refill_addr;
    logic        refill_valid;
    cache_line_t refill_line;

    integer      seed;
    int          cycle;
    int          errors;
    int          checks;
    int          tests;
    int          refill_cycle;
    way_onehot_t fill_seen;

    // Reference tags and ranks. Rank 0 is MRU.
    bit                      m_valid [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0] m_tag   [`CACHE_SETS][`CACHE_WAYS];
    int                      m_rank  [`CACHE_SETS][`CACHE_WAYS];

    cache_tb_clk u_clk (.clk(clk));

    lru_cache_top i_lru_cache_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_addr     (req_addr),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_line  (refill_line)
    );

    bind lru_cache_top cache_assert u_cache_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .refill_req   (refill_req),
        .refill_valid (refill_valid)
    );

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic cache_line_t line_at(input logic [31:0] base);
        cache_line_t line;
        for (int i = 0; i < WORDS; i++) begin
            line[i*32 +: 32] = word_at(base + 32'(i * 4));
        end
        return line;
    endfunction

    function automatic cache_addr_t make_addr(input logic [19:0] tag, input int set,
                                              input int word);
        return {tag, 6'(set), 4'(word), 2'b00};
    endfunction

    function automatic int assert_failures();
        return i_lru_cache_top.u_cache_assert.fail_answer
             + i_lru_cache_top.u_cache_assert.fail_refill
             + i_lru_cache_top.u_cache_assert.fail_resp;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
        end
    endtask

    task automatic model_reset();
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_rank[s][w]  = `CACHE_WAYS - 1 - w;  // Way 0 starts as LRU.
            end
        end
    endtask

    // Hit way, or else the fill way for a miss.
    task automatic model_lookup(input cache_addr_t a, output bit hit, output int way);
        int s;
        s   = int'(a.index);
        hit = 1'b0;
        way = m_rank[s][`CACHE_WAYS-1];
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                way = w;
            end
        end
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a.tag) begin
                hit = 1'b1;
                way = w;
            end
        end
    endtask

    task automatic model_touch(input int s, input int way);
        int pos;
        pos = 0;
        for (int f = 0; f < `CACHE_WAYS; f++) begin
            if (m_rank[s][f] == way) begin
                pos = f;
            end
        end
        for (int f = pos; f > 0; f--) begin
            m_rank[s][f] = m_rank[s][f-1];
        end
        m_rank[s][0] = way;
    endtask

    // One request. A stray request can be held during the busy cycle after it.
    task automatic access(input cache_addr_t a, input bit inject);
        bit          hit;
        int          way;
        int          s;
        cache_addr_t stray;
        s         = int'(a.index);
        stray     = a;
        stray.tag = a.tag ^ 20'h8_0000;  // Would miss if accepted.
        model_lookup(a, hit, way);
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        #1;
        req      = 1'b1;
        req_addr = a;
        @(posedge clk);
        #1;
        req      = inject;
        req_addr = stray;
        @(negedge clk);
        check_val("ready", 32'(ready), 32'd0);
        check_val("resp_valid", 32'(resp_valid), 32'(hit));
        check_val("refill_req", 32'(refill_req), 32'(!hit));
        if (hit) begin
            check_val("resp_data", resp_data, word_at({a[31:2], 2'b00}));
        end else begin
            check_val("refill_addr", refill_addr, {a[31:6], 6'b0});
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        if (!hit) begin
            @(negedge clk);
            while (!resp_valid) @(negedge clk);
            check_val("resp_valid cycle", cycle, refill_cycle + 1);
            check_val("tag_wr_way", 32'(fill_seen), 32'd1 << way);
            check_val("resp_data", resp_data, word_at({a[31:2], 2'b00}));
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = a.tag;
        end
        model_touch(s, way);
        @(negedge clk);
        check_val("ready", 32'(ready), 32'd1);
    endtask

    // Memory returns the line after 1 to 6 cycles.
    initial begin : memory_model
        int          delay;
        logic [31:0] line_addr;
        refill_valid = 1'b0;
        refill_line  = '0;
        refill_cycle = 0;
        forever begin
            @(negedge clk);
            if (rst_n && refill_req) begin
                line_addr = refill_addr;
                delay     = 1 + int'($unsigned($random(seed)) % 32'd6);
                repeat (delay) @(posedge clk);
                #1;
                refill_valid = 1'b1;
                refill_line  = line_at(line_addr);
                @(negedge clk);
                refill_cycle = cycle;
                fill_seen    = i_lru_cache_top.tag_wr_way;
                @(posedge clk);
                #1;
                refill_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle = cycle + 1;
        end
        $display("Timeout after %0d cycles without finishing the tests", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        int          mark;
        int          total;
        int          s;
        int          t;
        int          w;
        logic [19:0] tags [5];
        seed     = 75;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        rst_n    = 1'b0;
        req      = 1'b0;
        req_addr = '0;
        model_reset();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        mark = errors;
        @(negedge clk);
        check_val("ready", 32'(ready), 32'd1);
        check_val("resp_valid", 32'(resp_valid), 32'd0);
        check_val("refill_req", 32'(refill_req), 32'd0);
        access(32'h0001_2344, 1'b0);
        report_test("reset and first miss", mark);

        mark = errors;
        access(32'h0001_2340, 1'b0);
        access(32'h0001_237c, 1'b0);
        access(32'h0001_2360, 1'b0);
        report_test("refill data and line hits", mark);

        mark = errors;
        tags = '{20'h0a001, 20'h0b002, 20'h0c003, 20'h0d004, 20'h0e005};
        for (int i = 0; i < 4; i++) begin
            access(make_addr(tags[i], 9, i), 1'b0);
            check_val("tag_wr_way", 32'(fill_seen), 32'd1 << i);  // Fills in way order.
        end
        for (int i = 0; i < 4; i++) begin
            access(make_addr(tags[i], 9, 15 - i), 1'b0);
        end
        access(make_addr(tags[0], 9, 7), 1'b0);  // Way 1 becomes LRU.
        access(make_addr(tags[4], 9, 2), 1'b0);
        check_val("tag_wr_way", 32'(fill_seen), 32'h2);
        access(make_addr(tags[0], 9, 4), 1'b0);
        access(make_addr(tags[2], 9, 5), 1'b0);
        access(make_addr(tags[3], 9, 6), 1'b0);
        access(make_addr(tags[1], 9, 8), 1'b0);
        report_test("fill order and LRU eviction", mark);

        mark = errors;
        access(make_addr(20'h12345, 20, 3), 1'b1);
        access(make_addr(20'h12345, 20, 8), 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_val("resp_valid", 32'(resp_valid), 32'd0);
            check_val("refill_req", 32'(refill_req), 32'd0);
        end
        report_test("request while busy", mark);

        mark = errors;
        for (int i = 0; i < 300; i++) begin
            s = 3 + int'($unsigned($random(seed)) % 32'd3);
            t = int'($unsigned($random(seed)) % 32'd6);
            w = int'($unsigned($random(seed)) % 32'd16);
            access(make_addr(20'(32'h0004_0000 + t * 32'h1357), s, w), 1'b0);
        end
        report_test("random mix", mark);

        total = errors + assert_failures();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, total);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/cache_tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb_clk #(
    parameter int HALF_PERIOD = 4  // 8 ns period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

`define CACHE_WAYS      4
`define CACHE_SETS      64

// Address split is tag, index, offset from high to low.
`define CACHE_INDEX_W   6    // Bits 11 to 6.
`define CACHE_OFFSET_W  6    // Byte within a line.
`define CACHE_TAG_W     20   // Bits 31 to 12.

`define CACHE_LINE_W    512
`define CACHE_ADDR_W    32

`endif

// File: list.f
+incdir+include
verilog/cache_pkg.sv
verilog/set_array.sv
verilog/lru_way_sel.sv
verilog/cache_ctrl.sv
verilog/lru_cache_top.sv
bench/cache_assert.sv
bench/cache_tb_clk.sv
bench/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb \
    -f list.f --Mdir obj_dir -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Raise the error limit so bound assertion failures do not stop the run early.
output=$(./obj_dir/cache_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           req,
    input  wire cache_addr_t                    req_addr,
    output logic                                ready,
    output logic                                resp_valid,
    output logic [31:0]                         resp_data,
    output logic                                refill_req,
    output logic [`CACHE_ADDR_W-1:0]            refill_addr,
    input  wire logic                           refill_valid,
    input  wire cache_line_t                    refill_line,
    output logic [`CACHE_INDEX_W-1:0]           tag_index,
    output way_onehot_t                         tag_wr_way,
    output tag_entry_t                          tag_wr_entry,
    input  wire tag_entry_t [`CACHE_WAYS-1:0]   tag_rd,
    output logic [`CACHE_INDEX_W-1:0]           data_index,
    output way_onehot_t                         data_wr_way,
    output cache_line_t                         data_wr_line,
    input  wire cache_line_t [`CACHE_WAYS-1:0]  data_rd,
    output logic [`CACHE_INDEX_W-1:0]           lru_index,
    output way_onehot_t                         lru_touch,
    output logic                                lru_en,
    input  wire way_onehot_t                    lru_victim
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } state_t;

    localparam int WORD_W = 32;

    state_t      state;
    logic        refilled_q;
    cache_addr_t addr_q;
    way_onehot_t hit_way;
    way_onehot_t fill_way;
    logic        hit;
    logic        refill_fire;
    cache_line_t hit_line;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            refilled_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        state      <= ST_IDLE;
                        refilled_q <= 1'b0;
                    end else begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (refill_valid) begin
                        state      <= ST_LOOKUP; // Re-lookup hits the new line.
                        refilled_q <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_q <= req_addr;
        end
    end

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_way[w] = tag_rd[w].valid && (tag_rd[w].tag == addr_q.tag);
        end
    end

    assign hit = |hit_way;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_line = hit_line | data_rd[w];
            end
        end
    end

    // Lowest invalid way wins over the LRU choice.
    always_comb begin
        fill_way = lru_victim;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!tag_rd[w].valid) begin
                fill_way = way_onehot_t'(1) << w;
            end
        end
    end

    assign refill_fire = (state == ST_REFILL) && refill_valid;

    assign ready       = (state == ST_IDLE);
    assign resp_valid  = (state == ST_LOOKUP) && hit;
    assign resp_data   = hit_line[addr_q.offset[`CACHE_OFFSET_W-1:2] * WORD_W +: WORD_W];
    assign refill_req  = (state == ST_LOOKUP) && !hit;
    assign refill_addr = {addr_q.tag, addr_q.index, {`CACHE_OFFSET_W{1'b0}}};

    assign tag_index    = addr_q.index;
    assign tag_wr_way   = refill_fire ? fill_way : '0;
    assign tag_wr_entry = '{valid: 1'b1, tag: addr_q.tag};

    assign data_index   = addr_q.index;
    assign data_wr_way  = refill_fire ? fill_way : '0;
    assign data_wr_line = refill_line;

    // The re-lookup after a refill does not touch the rank again.
    assign lru_index = addr_q.index;
    assign lru_touch = (state == ST_REFILL) ? fill_way : hit_way;
    assign lru_en    = refill_fire || (resp_valid && !refilled_q);

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_WAYS-1:0] way_onehot_t;

    // Field 0 holds the MRU way number, the top field the LRU way.
    typedef logic [`CACHE_WAYS-1:0][1:0] lru_rank_t;

    typedef struct packed {
        logic                    valid;
        logic [`CACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [`CACHE_LINE_W-1:0] cache_line_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } cache_addr_t;

endpackage

`default_nettype wire

// File: verilog/lru_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module lru_cache_top
    import cache_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req,
    input  wire cache_addr_t          req_addr,
    output logic                      ready,
    output logic                      resp_valid,
    output logic [31:0]               resp_data,
    output logic                      refill_req,
    output logic [`CACHE_ADDR_W-1:0]  refill_addr,
    input  wire logic                 refill_valid,
    input  wire cache_line_t          refill_line
);

    logic [`CACHE_INDEX_W-1:0]     tag_index;
    way_onehot_t                   tag_wr_way;
    tag_entry_t                    tag_wr_entry;
    tag_entry_t [`CACHE_WAYS-1:0]  tag_rd;
    logic [`CACHE_INDEX_W-1:0]     data_index;
    way_onehot_t                   data_wr_way;
    cache_line_t                   data_wr_line;
    cache_line_t [`CACHE_WAYS-1:0] data_rd;
    logic [`CACHE_INDEX_W-1:0]     lru_index;
    way_onehot_t                   lru_touch;
    logic                          lru_en;
    way_onehot_t                   lru_victim;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_addr     (req_addr),
        .ready        (ready),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .refill_req   (refill_req),
        .refill_addr  (refill_addr),
        .refill_valid (refill_valid),
        .refill_line  (refill_line),
        .tag_index    (tag_index),
        .tag_wr_way   (tag_wr_way),
        .tag_wr_entry (tag_wr_entry),
        .tag_rd       (tag_rd),
        .data_index   (data_index),
        .data_wr_way  (data_wr_way),
        .data_wr_line (data_wr_line),
        .data_rd      (data_rd),
        .lru_index    (lru_index),
        .lru_touch    (lru_touch),
        .lru_en       (lru_en),
        .lru_victim   (lru_victim)
    );

    set_array #(.entry_t(tag_entry_t)) u_tags (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (tag_index),
        .wr_way     (tag_wr_way),
        .wr_entry   (tag_wr_entry),
        .rd_entries (tag_rd)
    );

    set_array #(.entry_t(cache_line_t)) u_data (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (data_index),
        .wr_way     (data_wr_way),
        .wr_entry   (data_wr_line),
        .rd_entries (data_rd)
    );

    lru_way_sel u_lru (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (lru_index),
        .touch  (lru_touch),
        .en     (lru_en),
        .victim (lru_victim)
    );

endmodule

`default_nettype wire

// File: verilog/lru_way_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module lru_way_sel
    import cache_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`CACHE_INDEX_W-1:0]  index,
    input  wire way_onehot_t                touch,
    input  wire logic                       en,
    output way_onehot_t                     victim
);

    localparam lru_rank_t RANK_RESET = {2'd0, 2'd1, 2'd2, 2'd3}; // Way 0 is LRU.

    lru_rank_t  rank [`CACHE_SETS];
    lru_rank_t  cur_rank;
    lru_rank_t  nxt_rank;
    logic [1:0] touch_num;
    logic [1:0] touch_pos;

    assign cur_rank = rank[index];

    // One-hot to way number.
    always_comb begin
        touch_num = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (touch[w]) begin
                touch_num = 2'(w);
            end
        end
    end

    // Ranks are a permutation, so exactly one field matches.
    always_comb begin
        touch_pos = '0;
        for (int f = 0; f < `CACHE_WAYS; f++) begin
            if (cur_rank[f] == touch_num) begin
                touch_pos = 2'(f);
            end
        end
    end

    always_comb begin
        nxt_rank = cur_rank;
        for (int f = 1; f < `CACHE_WAYS; f++) begin
            if (f <= int'(touch_pos)) begin
                nxt_rank[f] = cur_rank[f-1]; // Shift toward LRU.
            end
        end
        nxt_rank[0] = touch_num;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                rank[s] <= RANK_RESET;
            end
        end else if (en) begin
            rank[index] <= nxt_rank;
        end
    end

    assign victim = way_onehot_t'(1) << cur_rank[`CACHE_WAYS-1];

endmodule

`default_nettype wire

// File: verilog/set_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module set_array
    import cache_pkg::*;
#(
    parameter type entry_t = tag_entry_t
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [`CACHE_INDEX_W-1:0]  index,
    input  wire way_onehot_t                wr_way,
    input  wire entry_t                     wr_entry,
    output entry_t [`CACHE_WAYS-1:0]        rd_entries
);

    entry_t mem [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (wr_way[w]) begin
                    mem[index][w] <= wr_entry; // Only the selected way changes.
                end
            end
        end
    end

    // All ways of the set are visible at once.
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            rd_entries[w] = mem[index][w];
        end
    end

endmodule

`default_nettype wire
